/* src/exec_pkg.sv */
// Execute stage shared definitions
// Widths, unit positions, micro-op codes, trap causes and operand B union
`default_nettype none

package exec_pkg;

    // ------------------------------------------------------------------------
    // Widths and functional unit positions
    // ------------------------------------------------------------------------
    localparam int XLEN       = 32;             // Data word width
    localparam int REG_ADDR_W = 5;              // Register address width
    localparam int UOP_W      = 5;              // Micro-op width
    localparam int FU_W       = 5;              // One-hot unit field width

    localparam int P_FU_ALU   = 0;              // Integer ALU
    localparam int P_FU_MUL   = 1;              // Multiply / divide
    localparam int P_FU_LSU   = 2;              // Load / store address
    localparam int P_FU_CFU   = 3;              // Control flow
    localparam int P_FU_CSR   = 4;              // CSR pass-through

    // ALU micro-ops
    localparam logic [UOP_W-1:0] ALU_ADD  = 5'b00001;
    localparam logic [UOP_W-1:0] ALU_SUB  = 5'b00010;
    localparam logic [UOP_W-1:0] ALU_XOR  = 5'b00011;
    localparam logic [UOP_W-1:0] ALU_OR   = 5'b00100;
    localparam logic [UOP_W-1:0] ALU_AND  = 5'b00101;
    localparam logic [UOP_W-1:0] ALU_SLL  = 5'b00110;
    localparam logic [UOP_W-1:0] ALU_SRL  = 5'b00111;
    localparam logic [UOP_W-1:0] ALU_SRA  = 5'b01000;
    localparam logic [UOP_W-1:0] ALU_SLT  = 5'b01001;
    localparam logic [UOP_W-1:0] ALU_SLTU = 5'b01010;

    // Multiply / divide micro-ops
    localparam logic [UOP_W-1:0] MUL_MULU = 5'b00001; // Lo to A, hi to B
    localparam logic [UOP_W-1:0] MUL_DIVU = 5'b00010; // Quotient to A, rem to B

    // Control flow, conditional branches live in the 00xxx space
    localparam logic [UOP_W-1:0] CFU_BEQ       = 5'b00001;
    localparam logic [UOP_W-1:0] CFU_BNE       = 5'b00010;
    localparam logic [UOP_W-1:0] CFU_BLT       = 5'b00011;
    localparam logic [UOP_W-1:0] CFU_BGE       = 5'b00100;
    localparam logic [UOP_W-1:0] CFU_BLTU      = 5'b00101;
    localparam logic [UOP_W-1:0] CFU_BGEU      = 5'b00110;
    localparam logic [UOP_W-1:0] CFU_JALI      = 5'b10001;
    localparam logic [UOP_W-1:0] CFU_JALR      = 5'b10010;
    localparam logic [UOP_W-1:0] CFU_TAKEN     = 5'b11001; // Rewritten branch
    localparam logic [UOP_W-1:0] CFU_NOT_TAKEN = 5'b11000;

    // Load / store micro-op fields
    localparam int LSU_LOAD  = 3;               // Load flag bit
    localparam int LSU_STORE = 4;               // Store flag bit
    localparam logic [1:0] LSU_W_BYTE = 2'b00;  // Width in uop[1:0]
    localparam logic [1:0] LSU_W_HALF = 2'b01;
    localparam logic [1:0] LSU_W_WORD = 2'b10;

    // Trap causes
    localparam int TRAP_CAUSE_W = 6;
    localparam logic [TRAP_CAUSE_W-1:0] TRAP_LDALIGN = 6'd4; // Load misaligned
    localparam logic [TRAP_CAUSE_W-1:0] TRAP_STALIGN = 6'd6; // Store misaligned

    localparam int MULDIV_STEPS = 32;           // One bit per step

    // Pipeline register payload: rd, A, B, uop, fu, trap
    localparam int PIPE_W = REG_ADDR_W + 2*XLEN + UOP_W + FU_W + 1;

    // Operand B is either data or a trap cause
    typedef union packed {
        logic [XLEN-1:0] data;                  // Plain result word
        struct packed {
            logic [XLEN-TRAP_CAUSE_W-1:0] pad;  // Always zero
            logic [TRAP_CAUSE_W-1:0]      cause;
        } trap;
    } exec_opr_b_u;

endpackage

`default_nettype wire

/* src/exec_alu.sv */
// Integer ALU
// Logic, shifts, add/sub and set-less-than. One subtractor doubles as the
// comparator for both ALU and branch users
`timescale 1ns/1ps
`default_nettype none

module exec_alu
    import exec_pkg::*;
(
    input  logic [UOP_W-1:0] i_uop,          // ALU micro-op
    input  logic [XLEN-1:0]  i_lhs,          // Left hand operand
    input  logic [XLEN-1:0]  i_rhs,          // Right hand operand
    input  logic             i_cmp_unsigned, // Unsigned compare from branch
    output logic [XLEN-1:0]  o_result,       // Selected ALU result
    output logic [XLEN-1:0]  o_sum,          // Plain lhs + rhs
    output logic             o_lt,           // lhs < rhs
    output logic             o_eq            // lhs == rhs
);

    logic                    cmp_u;          // Treat operands as unsigned
    logic [XLEN:0]           diff;           // One extra bit for the borrow
    logic [$clog2(XLEN)-1:0] shamt;

    assign cmp_u = i_cmp_unsigned || (i_uop == ALU_SLTU);
    assign shamt = i_rhs[$clog2(XLEN)-1:0];

    // ------------------------------------------------------------------------
    // Adder and shared subtract / compare
    // ------------------------------------------------------------------------
    assign o_sum = i_lhs + i_rhs;            // Address and jalr users too

    // Extend by sign or zero so bit XLEN is the less-than flag
    assign diff = {~cmp_u & i_lhs[XLEN-1], i_lhs}
                - {~cmp_u & i_rhs[XLEN-1], i_rhs};

    assign o_lt = diff[XLEN];
    assign o_eq = (i_lhs == i_rhs);

    // ------------------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------------------
    always_comb begin
        case (i_uop)
            ALU_ADD:  o_result = o_sum;
            ALU_SUB:  o_result = diff[XLEN-1:0];     // Low bits of subtract
            ALU_XOR:  o_result = i_lhs ^ i_rhs;
            ALU_OR:   o_result = i_lhs | i_rhs;
            ALU_AND:  o_result = i_lhs & i_rhs;
            ALU_SLL:  o_result = i_lhs << shamt;
            ALU_SRL:  o_result = i_lhs >> shamt;
            ALU_SRA:  o_result = $signed(i_lhs) >>> shamt;
            ALU_SLT,
            ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, o_lt}; // Signedness in cmp_u
            default:  o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/exec_muldiv.sv */
// Iterative unsigned multiply / divide unit
// Shift-add multiplier and restoring divider on one 64-bit accumulator,
// one bit per cycle for MULDIV_STEPS cycles
`timescale 1ns/1ps
`default_nettype none

module exec_muldiv
    import exec_pkg::*;
(
    input  logic             g_clk,
    input  logic             i_rst_n,
    input  logic             i_valid,     // Start request
    input  logic             i_flush,     // Abort or result consumed
    input  logic [UOP_W-1:0] i_uop,       // MUL_MULU or MUL_DIVU
    input  logic [XLEN-1:0]  i_rs1,       // Multiplier / dividend
    input  logic [XLEN-1:0]  i_rs2,       // Multiplicand / divisor
    output logic             o_ready,     // Result held and valid
    output logic [XLEN-1:0]  o_result_lo, // Product lo or quotient
    output logic [XLEN-1:0]  o_result_hi  // Product hi or remainder
);

    logic                            running;   // Steps in progress
    logic                            is_div;    // Latched op kind
    logic                            start;
    logic [$clog2(MULDIV_STEPS)-1:0] count;     // Step counter
    logic [2*XLEN-1:0]               acc;       // {hi/rem, lo/quotient}
    logic [XLEN-1:0]                 opnd;      // Multiplicand or divisor
    logic [XLEN:0]                   mul_hi;    // Upper half plus carry
    logic [XLEN:0]                   rem_shift; // Partial remainder << 1
    logic [XLEN:0]                   div_trial;
    logic [2*XLEN-1:0]               acc_step;

    assign start = !running && !o_ready && i_valid;

    // ------------------------------------------------------------------------
    // One step of either algorithm
    // ------------------------------------------------------------------------
    assign mul_hi    = {1'b0, acc[2*XLEN-1:XLEN]}
                     + ({(XLEN+1){acc[0]}} & {1'b0, opnd}); // Add if lsb set
    assign rem_shift = acc[2*XLEN-1:XLEN-1];
    assign div_trial = rem_shift - {1'b0, opnd};  // Zero divisor always fits

    always_comb begin
        if (is_div) begin
            if (!div_trial[XLEN]) begin
                acc_step = {div_trial[XLEN-1:0], acc[XLEN-2:0], 1'b1};
            end else begin
                acc_step = {acc[2*XLEN-2:0], 1'b0}; // Restore, quotient bit 0
            end
        end else begin
            acc_step = {mul_hi, acc[XLEN-1:1]};     // Shift right with carry
        end
    end

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------
    always_ff @(posedge g_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            running <= 1'b0;
            o_ready <= 1'b0;
            count   <= '0;
        end else if (i_flush) begin
            running <= 1'b0;                        // Back to idle
            o_ready <= 1'b0;
        end else if (start) begin
            running <= 1'b1;
            count   <= '0;
        end else if (running) begin
            count <= count + 1'b1;
            if (count == MULDIV_STEPS - 1) begin
                running <= 1'b0;
                o_ready <= 1'b1;                    // Held until flush
            end
        end
    end

    // Datapath
    always_ff @(posedge g_clk) begin
        if (start && !i_flush) begin
            acc    <= {{XLEN{1'b0}}, i_rs1};
            opnd   <= i_rs2;
            is_div <= (i_uop == MUL_DIVU);
        end else if (running) begin
            acc <= acc_step;
        end
    end

    assign o_result_lo = acc[XLEN-1:0];
    assign o_result_hi = acc[2*XLEN-1:XLEN];

    a_no_ready_while_running: assert property (@(posedge g_clk) disable iff (!i_rst_n)
        !(o_ready && running));

    a_flush_to_idle: assert property (@(posedge g_clk) disable iff (!i_rst_n)
        i_flush |=> (!running && !o_ready));

endmodule

`default_nettype wire

/* src/exec_branch.sv */
// Control-flow unit
// Evaluates branch conditions, rewrites conditional branch micro-ops and
// picks the jump target
`timescale 1ns/1ps
`default_nettype none

module exec_branch
    import exec_pkg::*;
(
    input  logic             i_en,           // Control-flow unit selected
    input  logic [UOP_W-1:0] i_uop,
    input  logic             i_lt,           // From shared ALU comparator
    input  logic             i_eq,
    input  logic [XLEN-1:0]  i_sum,          // rs1 + imm for jalr
    input  logic [XLEN-1:0]  i_opr_c,        // Precomputed pc-relative target
    output logic             o_cmp_unsigned, // To ALU comparator
    output logic [UOP_W-1:0] o_uop,          // Rewritten micro-op
    output logic [XLEN-1:0]  o_target
);

    logic cond;     // Conditional branch
    logic taken;

    assign o_cmp_unsigned = i_en && (i_uop == CFU_BLTU || i_uop == CFU_BGEU);

    always_comb begin
        cond  = i_en;
        taken = 1'b0;
        case (i_uop)
            CFU_BEQ:  taken =  i_eq;
            CFU_BNE:  taken = !i_eq;
            CFU_BLT,
            CFU_BLTU: taken =  i_lt;            // Signedness set in ALU
            CFU_BGE,
            CFU_BGEU: taken = !i_lt;
            default:  cond  = 1'b0;             // Jumps keep their code
        endcase
    end

    assign o_uop = cond ? (taken ? CFU_TAKEN : CFU_NOT_TAKEN) : i_uop;

    // Bit 0 always cleared
    assign o_target = {(i_uop == CFU_JALR ? i_sum[XLEN-1:1] : i_opr_c[XLEN-1:1]), 1'b0};

endmodule

`default_nettype wire

/* src/exec_pipe_reg.sv */
// One-entry pipeline register
// Valid/busy back-pressure with flush
`timescale 1ns/1ps
`default_nettype none

module exec_pipe_reg #(
    parameter int RLEN = 8                  // Payload width
) (
    input  logic            g_clk,
    input  logic            i_rst_n,
    input  logic [RLEN-1:0] i_data,         // From stage N
    input  logic            i_valid,
    input  logic            i_flush,
    input  logic            i_busy,         // Stage N+1 stalled
    output logic            o_busy,         // Holding a blocked word
    output logic [RLEN-1:0] o_data,         // To stage N+1
    output logic            o_valid
);

    logic load;

    assign o_busy = o_valid && i_busy;
    assign load   = i_valid && !o_busy;

    always_ff @(posedge g_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;
        end else if (load) begin
            o_valid <= 1'b1;
        end else if (!i_busy) begin
            o_valid <= 1'b0;                // Consumed, nothing new
        end
    end

    // Payload
    always_ff @(posedge g_clk) begin
        if (load) begin
            o_data <= i_data;
        end
    end

    a_hold_when_busy: assert property (@(posedge g_clk) disable iff (!i_rst_n)
        (o_valid && i_busy) |=> $stable(o_data));

endmodule

`default_nettype wire

/* src/exec_stage.sv */
// Execute stage top level
// Routes a decoded word to ALU, mul/div, load/store, control-flow or CSR,
// registers the result and drives forwarding for the current word
`timescale 1ns/1ps
`default_nettype none

module exec_stage
    import exec_pkg::*;
(
    input  logic                  g_clk,
    input  logic                  i_rst_n,
    input  logic [REG_ADDR_W-1:0] i_s2_rd,     // Destination register
    input  logic [XLEN-1:0]       i_s2_opr_a,
    input  logic [XLEN-1:0]       i_s2_opr_b,
    input  logic [XLEN-1:0]       i_s2_opr_c,
    input  logic [UOP_W-1:0]      i_s2_uop,
    input  logic [FU_W-1:0]       i_s2_fu,     // One-hot unit select
    input  logic                  i_s2_trap,   // Trap raised upstream
    input  logic                  i_s2_valid,
    output logic                  o_s2_busy,
    input  logic                  i_flush,
    output logic [REG_ADDR_W-1:0] o_fwd_rd,
    output logic [XLEN-1:0]       o_fwd_wdata,
    output logic                  o_fwd_load,
    output logic                  o_fwd_csr,
    output logic [REG_ADDR_W-1:0] o_s3_rd,
    output logic [XLEN-1:0]       o_s3_opr_a,
    output logic [XLEN-1:0]       o_s3_opr_b,
    output logic [UOP_W-1:0]      o_s3_uop,
    output logic [FU_W-1:0]       o_s3_fu,
    output logic                  o_s3_trap,
    output logic                  o_s3_valid,
    input  logic                  i_s3_busy
);

    logic fu_alu, fu_mul, fu_lsu, fu_cfu, fu_csr;
    logic progress, p_busy, mul_ready, cmp_unsigned, alu_lt, alu_eq;
    logic lsu_load, lsu_store, misalign, n_trap;
    logic [XLEN-1:0] alu_result, alu_sum, mul_lo, mul_hi, br_target, n_opr_a;
    logic [UOP_W-1:0] br_uop, n_uop;
    logic [TRAP_CAUSE_W-1:0] trap_cause;
    exec_opr_b_u n_opr_b;

    assign fu_alu = i_s2_fu[P_FU_ALU];
    assign fu_mul = i_s2_fu[P_FU_MUL];
    assign fu_lsu = i_s2_fu[P_FU_LSU];
    assign fu_cfu = i_s2_fu[P_FU_CFU];
    assign fu_csr = i_s2_fu[P_FU_CSR];

    assign progress  = i_s2_valid && !o_s2_busy;
    assign o_s2_busy = p_busy || (i_s2_valid && fu_mul && !mul_ready); // Wait on mul/div

    exec_alu u_alu (
        .i_uop(fu_alu ? i_s2_uop : ALU_ADD), .i_lhs(i_s2_opr_a), .i_rhs(i_s2_opr_b),
        .i_cmp_unsigned(cmp_unsigned), .o_result(alu_result), .o_sum(alu_sum),
        .o_lt(alu_lt), .o_eq(alu_eq));

    exec_muldiv u_muldiv (
        .g_clk(g_clk), .i_rst_n(i_rst_n), .i_valid(fu_mul && i_s2_valid),
        .i_flush(progress || i_flush), .i_uop(i_s2_uop), .i_rs1(i_s2_opr_a),
        .i_rs2(i_s2_opr_b), .o_ready(mul_ready), .o_result_lo(mul_lo), .o_result_hi(mul_hi));

    exec_branch u_branch (
        .i_en(fu_cfu), .i_uop(i_s2_uop), .i_lt(alu_lt), .i_eq(alu_eq), .i_sum(alu_sum),
        .i_opr_c(i_s2_opr_c), .o_cmp_unsigned(cmp_unsigned), .o_uop(br_uop),
        .o_target(br_target));

    // ------------------------------------------------------------------------
    // Load / store alignment and trap
    // ------------------------------------------------------------------------
    assign lsu_load  = fu_lsu && i_s2_uop[LSU_LOAD];
    assign lsu_store = fu_lsu && i_s2_uop[LSU_STORE];

    always_comb begin
        case (i_s2_uop[1:0])
            LSU_W_BYTE: misalign = 1'b0;
            LSU_W_HALF: misalign = alu_sum[0];
            LSU_W_WORD: misalign = |alu_sum[1:0];
            default:    misalign = 1'b0;
        endcase
    end

    assign n_trap     = i_s2_trap || ((lsu_load || lsu_store) && misalign);
    assign trap_cause = i_s2_trap ? TRAP_CAUSE_W'(i_s2_rd) :     // Upstream wins
                        lsu_load  ? TRAP_LDALIGN : TRAP_STALIGN;

    // ------------------------------------------------------------------------
    // Result mux
    // ------------------------------------------------------------------------
    assign n_opr_a = {XLEN{fu_alu}} & alu_result | {XLEN{fu_mul}} & mul_lo
                   | {XLEN{fu_lsu}} & alu_sum    | {XLEN{fu_cfu}} & br_target
                   | {XLEN{fu_csr}} & i_s2_opr_a;

    always_comb begin
        if (n_trap) begin
            n_opr_b.trap.pad   = '0;
            n_opr_b.trap.cause = trap_cause;
        end else begin
            n_opr_b.data = {XLEN{fu_mul}} & mul_hi
                         | {XLEN{fu_lsu || fu_csr}} & i_s2_opr_c;  // ALU, CFU give zero
        end
    end

    assign n_uop = fu_cfu ? br_uop : i_s2_uop;

    assign o_fwd_rd    = i_s2_rd;
    assign o_fwd_wdata = n_opr_a;
    assign o_fwd_load  = lsu_load;
    assign o_fwd_csr   = fu_csr;

    exec_pipe_reg #(.RLEN(PIPE_W)) u_pipe_reg (
        .g_clk(g_clk), .i_rst_n(i_rst_n),
        .i_data({i_s2_rd, n_opr_a, n_opr_b.data, n_uop, i_s2_fu, n_trap}),
        .i_valid(progress), .i_flush(i_flush), .i_busy(i_s3_busy), .o_busy(p_busy),
        .o_data({o_s3_rd, o_s3_opr_a, o_s3_opr_b, o_s3_uop, o_s3_fu, o_s3_trap}),
        .o_valid(o_s3_valid));

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// Testbench clock source
// Free-running clock, 8 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic o_clk                      // Stage clock
);

    localparam real HALF_PERIOD = 4.0;      // Half of 8 ns

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

/* testbench/tb_exec_stage.sv */
// Execute stage testbench
// Directed tests for ALU, control flow, load/store, CSR, traps, mul/div,
// back-pressure and flush
`timescale 1ns/1ps
`default_nettype none

module tb_exec_stage
    import exec_pkg::*;
();

    logic                  g_clk, rst_n, s2_trap, s2_valid, s2_busy, flush;
    logic                  fwd_load, fwd_csr, s3_trap, s3_valid, s3_busy;
    logic [REG_ADDR_W-1:0] s2_rd, fwd_rd, s3_rd;
    logic [XLEN-1:0]       s2_opr_a, s2_opr_b, s2_opr_c, fwd_wdata, s3_opr_a, s3_opr_b;
    logic [UOP_W-1:0]      s2_uop, s3_uop;
    logic [FU_W-1:0]       s2_fu, s3_fu;
    integer                seed;                // $random state

    tb_clock_gen u_clk (.o_clk(g_clk));

    exec_stage DUT (
        .g_clk(g_clk), .i_rst_n(rst_n), .i_s2_rd(s2_rd), .i_s2_opr_a(s2_opr_a),
        .i_s2_opr_b(s2_opr_b), .i_s2_opr_c(s2_opr_c), .i_s2_uop(s2_uop), .i_s2_fu(s2_fu),
        .i_s2_trap(s2_trap), .i_s2_valid(s2_valid), .o_s2_busy(s2_busy), .i_flush(flush),
        .o_fwd_rd(fwd_rd), .o_fwd_wdata(fwd_wdata), .o_fwd_load(fwd_load),
        .o_fwd_csr(fwd_csr), .o_s3_rd(s3_rd), .o_s3_opr_a(s3_opr_a), .o_s3_opr_b(s3_opr_b),
        .o_s3_uop(s3_uop), .o_s3_fu(s3_fu), .o_s3_trap(s3_trap), .o_s3_valid(s3_valid),
        .i_s3_busy(s3_busy));

    // ------------------------------------------------------------------------
    // Reference models
    // ------------------------------------------------------------------------
    function automatic logic [XLEN-1:0] alu_model(input logic [UOP_W-1:0] op,
                                                  input logic [XLEN-1:0] a, b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_XOR:  return a ^ b;
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_SLT:  return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: return {{(XLEN-1){1'b0}}, a < b};
            default:  return '0;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [UOP_W-1:0] op,
                                          input logic [XLEN-1:0] a, b);
        case (op)
            CFU_BEQ:  return a == b;
            CFU_BNE:  return a != b;
            CFU_BLT:  return $signed(a) < $signed(b);
            CFU_BGE:  return $signed(a) >= $signed(b);
            CFU_BLTU: return a < b;
            default:  return a >= b;            // BGEU
        endcase
    endfunction

    function automatic logic [UOP_W-1:0] lsu_uop(input logic load, input logic [1:0] width);
        lsu_uop            = '0;
        lsu_uop[LSU_LOAD]  = load;
        lsu_uop[LSU_STORE] = !load;
        lsu_uop[1:0]       = width;
    endfunction

    function automatic logic [FU_W-1:0] fu_sel(input int pos);
        fu_sel      = '0;
        fu_sel[pos] = 1'b1;                     // One-hot unit
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    // ------------------------------------------------------------------------
    // Word transfer
    // ------------------------------------------------------------------------
    task automatic drive_word(input logic [REG_ADDR_W-1:0] rd, input logic [XLEN-1:0] a, b, c,
                              input logic [UOP_W-1:0] uop, input logic [FU_W-1:0] fu,
                              input logic trap);
        s2_rd    = rd;
        s2_opr_a = a;
        s2_opr_b = b;
        s2_opr_c = c;
        s2_uop   = uop;
        s2_fu    = fu;
        s2_trap  = trap;
        s2_valid = 1'b1;
        #1;                                     // Forwarding paths settle
    endtask

    task automatic send_word(input logic [REG_ADDR_W-1:0] rd, input logic [XLEN-1:0] a, b, c,
                             input logic [UOP_W-1:0] uop, input logic [FU_W-1:0] fu,
                             input logic trap, input logic [XLEN-1:0] exp_a, exp_b,
                             input logic [UOP_W-1:0] exp_uop, input logic exp_trap);
        int          n;
        int          busy_cnt;
        exec_opr_b_u got_b;
        n        = 0;
        busy_cnt = 0;
        drive_word(rd, a, b, c, uop, fu, trap);
        if (!fu[P_FU_MUL]) check_value("o_fwd_wdata", fwd_wdata, exp_a);
        check_value("o_fwd_rd", fwd_rd, rd);
        check_value("o_fwd_load", fwd_load, fu[P_FU_LSU] && uop[LSU_LOAD]);
        check_value("o_fwd_csr", fwd_csr, fu[P_FU_CSR]);
        while (!s3_valid) begin
            if (n == 200) begin
                $display("Timeout at %0t ns: word for unit %b never left", $time, fu);
                $display("TEST FAIL");
                $fatal(1, "Timeout");
            end
            if (s2_busy) busy_cnt++;            // Stall cycles seen upstream
            n++;
            @(negedge g_clk);
        end
        s2_valid = 1'b0;
        check_value("o_s2_busy cycles", busy_cnt, fu[P_FU_MUL] ? MULDIV_STEPS + 1 : 0);
        check_value("o_s3_rd", s3_rd, rd);
        check_value("o_s3_opr_a", s3_opr_a, exp_a);
        check_value("o_s3_uop", s3_uop, exp_uop);
        check_value("o_s3_fu", s3_fu, fu);
        check_value("o_s3_trap", s3_trap, exp_trap);
        got_b = s3_opr_b;
        if (exp_trap) begin
            check_value("o_s3_opr_b.trap.cause", got_b.trap.cause, exp_b);
            check_value("o_s3_opr_b.trap.pad", got_b.trap.pad, '0);
        end else begin
            check_value("o_s3_opr_b", got_b.data, exp_b);
        end
        if (!s3_busy) begin
            @(negedge g_clk);                   // Downstream takes the word
            check_value("o_s3_valid", s3_valid, 1'b0);
        end
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic test_reset();
        check_value("o_s3_valid", s3_valid, 1'b0);
        check_value("o_s2_busy", s2_busy, 1'b0);
    endtask

    task automatic test_alu();
        logic [UOP_W-1:0] ops [10];
        logic [XLEN-1:0]  a, b;
        ops = '{ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
                ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU};
        foreach (ops[i]) begin
            for (int k = 0; k < 4; k++) begin
                a = $random(seed);
                b = $random(seed);
                if (k == 2) begin
                    a = 32'h8000_0000;          // Signed and unsigned disagree
                    b = 32'h0000_0001;
                end else if (k == 3) begin
                    a = 32'hffff_fff0;
                    b = 32'h0000_001f;          // Widest shift
                end
                send_word(REG_ADDR_W'($random(seed)), a, b, $random(seed), ops[i],
                          fu_sel(P_FU_ALU), 1'b0, alu_model(ops[i], a, b), '0, ops[i], 1'b0);
            end
        end
    endtask

    task automatic test_branch();
        logic [UOP_W-1:0] ops [6];
        logic [XLEN-1:0]  a_set [4];
        logic [XLEN-1:0]  b_set [4];
        logic [XLEN-1:0]  a, b, c, sum;
        ops   = '{CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE, CFU_BLTU, CFU_BGEU};
        a_set = '{32'd5, 32'd5, 32'hffff_ffff, 32'h0000_0001};
        b_set = '{32'd5, 32'd6, 32'h0000_0001, 32'hffff_ffff};   // Sign split pairs
        foreach (ops[i]) begin
            foreach (a_set[k]) begin
                c = $random(seed);
                send_word(5'd1, a_set[k], b_set[k], c, ops[i], fu_sel(P_FU_CFU), 1'b0,
                          {c[XLEN-1:1], 1'b0}, '0,
                          branch_taken(ops[i], a_set[k], b_set[k]) ? CFU_TAKEN : CFU_NOT_TAKEN,
                          1'b0);
            end
        end
        a   = $random(seed);
        b   = $random(seed);
        c   = $random(seed) | 32'h1;            // Odd target, bit 0 must clear
        sum = a + b;
        send_word(5'd2, a, b, c, CFU_JALI, fu_sel(P_FU_CFU), 1'b0,
                  {c[XLEN-1:1], 1'b0}, '0, CFU_JALI, 1'b0);
        send_word(5'd3, a, b, c, CFU_JALR, fu_sel(P_FU_CFU), 1'b0,
                  {sum[XLEN-1:1], 1'b0}, '0, CFU_JALR, 1'b0);
    endtask

    task automatic test_lsu_csr();
        logic [XLEN-1:0] a, c;
        a = $random(seed);
        c = $random(seed);
        send_word(5'd1, 32'h1000, 32'h8, c, lsu_uop(1'b1, LSU_W_WORD), fu_sel(P_FU_LSU), 1'b0,
                  32'h1008, c, lsu_uop(1'b1, LSU_W_WORD), 1'b0);
        send_word(5'd2, 32'h2001, 32'h1, c, lsu_uop(1'b0, LSU_W_HALF), fu_sel(P_FU_LSU), 1'b0,
                  32'h2002, c, lsu_uop(1'b0, LSU_W_HALF), 1'b0);
        send_word(5'd3, 32'h3000, 32'h3, c, lsu_uop(1'b1, LSU_W_BYTE), fu_sel(P_FU_LSU), 1'b0,
                  32'h3003, c, lsu_uop(1'b1, LSU_W_BYTE), 1'b0);
        // Misaligned accesses
        send_word(5'd4, 32'h1000, 32'h1, c, lsu_uop(1'b1, LSU_W_HALF), fu_sel(P_FU_LSU), 1'b0,
                  32'h1001, XLEN'(TRAP_LDALIGN), lsu_uop(1'b1, LSU_W_HALF), 1'b1);
        send_word(5'd5, 32'h1000, 32'h2, c, lsu_uop(1'b0, LSU_W_WORD), fu_sel(P_FU_LSU), 1'b0,
                  32'h1002, XLEN'(TRAP_STALIGN), lsu_uop(1'b0, LSU_W_WORD), 1'b1);
        // Upstream trap, cause carried in rd
        send_word(5'd13, 32'h10, 32'h20, c, ALU_ADD, fu_sel(P_FU_ALU), 1'b1,
                  32'h30, 32'd13, ALU_ADD, 1'b1);
        send_word(5'd7, a, 32'h0, c, 5'b00011, fu_sel(P_FU_CSR), 1'b0, a, c, 5'b00011, 1'b0);
    endtask

    task automatic test_muldiv();
        logic [XLEN-1:0]   a, b;
        logic [2*XLEN-1:0] prod;
        for (int k = 0; k < 4; k++) begin
            a    = $random(seed);
            b    = $random(seed);
            prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
            send_word(5'd8, a, b, '0, MUL_MULU, fu_sel(P_FU_MUL), 1'b0,
                      prod[XLEN-1:0], prod[2*XLEN-1:XLEN], MUL_MULU, 1'b0);
            b = (b >> (k * 8)) | 32'h1;         // Smaller divisors, never zero
            send_word(5'd9, a, b, '0, MUL_DIVU, fu_sel(P_FU_MUL), 1'b0,
                      a / b, a % b, MUL_DIVU, 1'b0);
        end
        a = $random(seed);
        send_word(5'd10, a, '0, '0, MUL_DIVU, fu_sel(P_FU_MUL), 1'b0, '1, a, MUL_DIVU, 1'b0);
    endtask

    task automatic test_backpressure();
        logic [XLEN-1:0]   a, b;
        logic [2*XLEN-1:0] prod;
        a       = $random(seed);
        b       = $random(seed);
        prod    = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        s3_busy = 1'b1;                         // Downstream stalled
        send_word(5'd9, a, b, '0, ALU_XOR, fu_sel(P_FU_ALU), 1'b0, a ^ b, '0, ALU_XOR, 1'b0);
        drive_word(5'd10, b, a, '0, MUL_MULU, fu_sel(P_FU_MUL), 1'b0);  // Second word waits
        for (int k = 0; k < MULDIV_STEPS + 8; k++) begin   // Runs past the mul/div wait
            check_value("o_s2_busy", s2_busy, 1'b1);
            check_value("o_s3_valid", s3_valid, 1'b1);
            check_value("o_s3_opr_a", s3_opr_a, a ^ b);
            check_value("o_s3_rd", s3_rd, 5'd9);
            @(negedge g_clk);
        end
        flush = 1'b1;
        @(negedge g_clk);
        flush    = 1'b0;
        s2_valid = 1'b0;
        s3_busy  = 1'b0;
        check_value("o_s3_valid", s3_valid, 1'b0);
        // Aborted mul/div restarts from idle
        send_word(5'd11, a, b, '0, MUL_MULU, fu_sel(P_FU_MUL), 1'b0,
                  prod[XLEN-1:0], prod[2*XLEN-1:XLEN], MUL_MULU, 1'b0);
    endtask

    initial begin
        seed     = 32'hc9b6;
        rst_n    = 1'b0;
        s2_rd    = '0;
        s2_opr_a = '0;
        s2_opr_b = '0;
        s2_opr_c = '0;
        s2_uop   = '0;
        s2_fu    = '0;
        s2_trap  = 1'b0;
        s2_valid = 1'b0;
        flush    = 1'b0;
        s3_busy  = 1'b0;
        repeat (16) @(posedge g_clk);
        @(negedge g_clk);
        rst_n = 1'b1;
        test_reset();
        test_alu();
        test_branch();
        test_lsu_csr();
        test_muldiv();
        test_backpressure();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
src/exec_pkg.sv
src/exec_alu.sv
src/exec_muldiv.sv
src/exec_branch.sv
src/exec_pipe_reg.sv
src/exec_stage.sv
testbench/tb_clock_gen.sv
testbench/tb_exec_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build the execute stage testbench with Verilator and run it.
# The exit status is zero only when the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_exec_stage -Mdir obj_dir -f filelist.f \
    && ./obj_dir/Vtb_exec_stage | tee /dev/stderr | grep -qx "TEST PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

exit 0
